// ==== hw/panel_defines.svh ====
`ifndef PANEL_DEFINES_SVH
`define PANEL_DEFINES_SVH

// panel geometry, 64 columns by two 16-row halves
`define PANEL_WIDTH 64
`define COL_BITS ($clog2(`PANEL_WIDTH))
`define PIXEL_HALFHEIGHT 16
`define ROW_BITS ($clog2(`PIXEL_HALFHEIGHT))

// framebuffer word address is {row, column}
`define FB_ADDR_BITS (`ROW_BITS + `COL_BITS)

// binary weighted bit planes per row
`define NUM_PLANES 4

// output enable time of plane 0, doubled for each later plane
`define OE_BASE_CYCLES 8

// register map, framebuffer bytes sit below the control register
`define CTRL_ADDR 16'h1000

// load value of the pixel fetch timer
`define FETCH_CYCLES 3

`endif

// ==== hw/axil_pkg.sv ====
package axil_pkg;

    // only the two responses this slave produces
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

    // decoded target of a bus access
    typedef enum logic [1:0] {
        ACC_FB,
        ACC_CTRL,
        ACC_BAD
    } axil_target_t;

    // master driven signals
    typedef struct packed {
        logic [15:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [15:0] araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // slave driven signals
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        axil_resp_t  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        axil_resp_t  rresp;
    } axil_rsp_t;

endpackage

// ==== hw/panel_pkg.sv ====
`include "panel_defines.svh"

package panel_pkg;

    // one pixel as stored by the host
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // one framebuffer word, bottom half pixel in the upper 16 bits
    typedef struct packed {
        rgb565_t bottom;
        rgb565_t top;
    } fb_word_t;

    // HUB75 connector pins
    // colour bits first so they can be taken as one slice
    typedef struct packed {
        logic                 r1;
        logic                 g1;
        logic                 b1;
        logic                 r2;
        logic                 g2;
        logic                 b2;
        logic [`ROW_BITS-1:0] a;
        logic                 shift_clk;
        logic                 latch;
        logic                 oe_n;
    } hub75_t;

    // scan sequencer states
    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_SHIFT_HI,
        S_SHIFT_LO,
        S_BLANK,
        S_LATCH,
        S_SHOW
    } scan_state_t;

endpackage

// ==== hw/timeout.sv ====
`timescale 1ns/1ps

module timeout #(
    parameter int COUNTER_WIDTH = 2
) (
    input  logic                     reset,
    input  logic                     clk_in,
    input  logic                     start,
    input  logic [COUNTER_WIDTH-1:0] value,
    output logic [COUNTER_WIDTH-1:0] counter,
    output logic                     running
);

    // start wins over the countdown, so a restart reloads at once
    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            counter <= value;
        end else if (counter != '0) begin
            counter <= counter - 1'b1;
        end
    end

    // busy until the count reaches zero
    assign running = (counter != '0);

endmodule

// ==== hw/framebuffer_ram.sv ====
`timescale 1ns/1ps
`include "panel_defines.svh"

module framebuffer_ram
    import panel_pkg::*;
(
    input  logic                     clk_in,
    input  logic                     we,
    input  logic [`FB_ADDR_BITS-1:0] waddr,
    input  fb_word_t                 wdata,
    input  logic [3:0]               wbe,
    input  logic                     re,
    input  logic [`FB_ADDR_BITS-1:0] raddr,
    output fb_word_t                 rdata
);
    localparam int DEPTH = 1 << `FB_ADDR_BITS;

    logic [31:0] mem [DEPTH];
    logic [31:0] wdata_bits;

    assign wdata_bits = wdata;

    // byte lanes written independently
    always_ff @(posedge clk_in) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (wbe[i]) begin
                    mem[waddr][i*8 +: 8] <= wdata_bits[i*8 +: 8];
                end
            end
        end
    end

    // registered read, holds its word while re is low
    always_ff @(posedge clk_in) begin
        if (re) begin
            rdata <= fb_word_t'(mem[raddr]);
        end
    end

endmodule

// ==== hw/framebuffer_fetch.sv ====
`timescale 1ns/1ps
`include "panel_defines.svh"

module framebuffer_fetch
    import panel_pkg::*;
(
    input  logic                     reset,
    input  logic                     clk_in,
    input  logic [`COL_BITS-1:0]     column_address,
    input  logic [`ROW_BITS-1:0]     row_address,
    input  logic                     pixel_load_start,
    input  fb_word_t                 ram_data_in,
    output logic [`FB_ADDR_BITS-1:0] ram_address,
    output logic                     ram_clk_enable,
    output logic                     load_busy,
    output rgb565_t                  pixeldata_top,
    output rgb565_t                  pixeldata_bottom
);
    // wide enough to hold the fetch load value
    localparam int TIMER_BITS = $clog2(`FETCH_CYCLES + 1);

    logic [TIMER_BITS-1:0] load_count;
    logic                  load_running;

    // column inverted, first column shifted is the far end of the panel
    assign ram_address = {row_address, ~column_address};

    timeout #(
        .COUNTER_WIDTH(TIMER_BITS)
    ) timeout_pixel_load (
        .reset  (reset),
        .clk_in (clk_in),
        .start  (pixel_load_start),
        .value  (TIMER_BITS'(`FETCH_CYCLES)),
        .counter(load_count),
        .running(load_running)
    );

    // ram reads every cycle the timer runs, the address is steady by then
    assign ram_clk_enable = load_running;
    assign load_busy      = load_running;

    // at count 1 the ram word from the previous read is settled
    // busy drops on this same edge
    always_ff @(posedge clk_in) begin
        if (reset) begin
            pixeldata_top    <= '0;
            pixeldata_bottom <= '0;
        end else if (load_count == TIMER_BITS'(1)) begin
            pixeldata_top    <= ram_data_in.top;
            pixeldata_bottom <= ram_data_in.bottom;
        end
    end

endmodule

// ==== hw/axil_fb_writer.sv ====
`timescale 1ns/1ps
`include "panel_defines.svh"

module axil_fb_writer
    import axil_pkg::*;
    import panel_pkg::*;
(
    input  logic                     clk_in,
    input  logic                     reset,
    input  axil_req_t                bus_req,
    output axil_rsp_t                bus_rsp,
    output logic                     fb_we,
    output logic [`FB_ADDR_BITS-1:0] fb_waddr,
    output fb_word_t                 fb_wdata,
    output logic [3:0]               fb_wbe,
    output logic                     scan_enable
);
    // handshake and pending response flags
    logic         awready_q;
    logic         bvalid_q;
    logic         arready_q;
    logic         rvalid_q;
    logic         enable_q;
    // response payload
    axil_resp_t   bresp_q;
    axil_resp_t   rresp_q;
    logic [31:0]  rdata_q;
    axil_target_t wr_target;
    axil_target_t rd_target;
    logic         wr_fire;
    logic         rd_fire;

    // framebuffer below the control register, control register alone above it
    function automatic axil_target_t decode(input logic [15:0] addr);
        if (addr < `CTRL_ADDR) begin
            return ACC_FB;
        end
        if (addr == `CTRL_ADDR) begin
            return ACC_CTRL;
        end
        return ACC_BAD;
    endfunction

    assign wr_target = decode(bus_req.awaddr);
    assign rd_target = decode(bus_req.araddr);

    // aw and w are taken together, valids are held until ready
    assign wr_fire = awready_q && bus_req.awvalid && bus_req.wvalid;
    assign rd_fire = arready_q && bus_req.arvalid;

    // framebuffer write goes straight out on the accepting edge
    assign fb_we    = wr_fire && (wr_target == ACC_FB);
    // byte address bits 11:2 select the word
    assign fb_waddr = bus_req.awaddr[`FB_ADDR_BITS+1:2];
    assign fb_wdata = fb_word_t'(bus_req.wdata);
    assign fb_wbe   = bus_req.wstrb;

    assign scan_enable = enable_q;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            awready_q <= 1'b0;
            bvalid_q  <= 1'b0;
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
            enable_q  <= 1'b0;
        end else begin
            // one cycle ready pulse, never while a response waits
            awready_q <= bus_req.awvalid && bus_req.wvalid && !awready_q && !bvalid_q;
            arready_q <= bus_req.arvalid && !arready_q && !rvalid_q;

            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (bus_req.bready) begin
                bvalid_q <= 1'b0;
            end

            if (rd_fire) begin
                rvalid_q <= 1'b1;
            end else if (bus_req.rready) begin
                rvalid_q <= 1'b0;
            end

            // enable bit lives in byte lane 0
            if (wr_fire && (wr_target == ACC_CTRL) && bus_req.wstrb[0]) begin
                enable_q <= bus_req.wdata[0];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (wr_fire) begin
            bresp_q <= (wr_target == ACC_BAD) ? RESP_SLVERR : RESP_OKAY;
        end
        // pixels are write only, so only the control register reads back
        if (rd_fire) begin
            rresp_q <= (rd_target == ACC_CTRL) ? RESP_OKAY : RESP_SLVERR;
            rdata_q <= (rd_target == ACC_CTRL) ? {31'b0, enable_q} : 32'b0;
        end
    end

    always_comb begin
        bus_rsp.awready = awready_q;
        bus_rsp.wready  = awready_q;
        bus_rsp.bvalid  = bvalid_q;
        bus_rsp.bresp   = bresp_q;
        bus_rsp.arready = arready_q;
        bus_rsp.rvalid  = rvalid_q;
        bus_rsp.rdata   = rdata_q;
        bus_rsp.rresp   = rresp_q;
    end

endmodule

// ==== hw/panel_scan.sv ====
`timescale 1ns/1ps
`include "panel_defines.svh"

module panel_scan
    import panel_pkg::*;
(
    input  logic                 clk_in,
    input  logic                 reset,
    input  logic                 enable,
    input  rgb565_t              pixeldata_top,
    input  rgb565_t              pixeldata_bottom,
    input  logic                 load_busy,
    output logic [`COL_BITS-1:0] column_address,
    output logic [`ROW_BITS-1:0] row_address,
    output logic                 pixel_load_start,
    output hub75_t               panel
);
    localparam int PLANE_BITS = $clog2(`NUM_PLANES);
    // longest show time is the last plane
    localparam int SHOW_BITS  = $clog2((`OE_BASE_CYCLES << (`NUM_PLANES - 1)) + 1);

    scan_state_t           state;
    logic [`COL_BITS-1:0]  col;
    logic [`ROW_BITS-1:0]  row;
    logic [PLANE_BITS-1:0] plane;
    logic [SHOW_BITS-1:0]  show_cnt;
    // row currently driven on the address pins
    logic [`ROW_BITS-1:0]  row_sel;
    // start already issued for this column
    logic                  fetch_started;

    assign column_address   = col;
    assign row_address      = row;
    // single start pulse on the first fetch cycle
    assign pixel_load_start = (state == S_FETCH) && !fetch_started;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state         <= S_IDLE;
            col           <= '0;
            row           <= '0;
            plane         <= '0;
            show_cnt      <= '0;
            row_sel       <= '0;
            fetch_started <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    // always begin a frame at the top
                    if (enable) begin
                        col   <= '0;
                        row   <= '0;
                        plane <= '0;
                        state <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (!fetch_started) begin
                        fetch_started <= 1'b1;
                    end else if (!load_busy) begin
                        fetch_started <= 1'b0;
                        state         <= S_SHIFT_HI;
                    end
                end
                S_SHIFT_HI: begin
                    state <= S_SHIFT_LO;
                end
                S_SHIFT_LO: begin
                    if (col == `COL_BITS'(`PANEL_WIDTH - 1)) begin
                        col   <= '0;
                        state <= S_BLANK;
                    end else begin
                        col   <= col + 1'b1;
                        state <= S_FETCH;
                    end
                end
                S_BLANK: begin
                    // address switches while the panel is dark
                    row_sel <= row;
                    state   <= S_LATCH;
                end
                S_LATCH: begin
                    show_cnt <= SHOW_BITS'((`OE_BASE_CYCLES << plane) - 1);
                    state    <= S_SHOW;
                end
                S_SHOW: begin
                    if (show_cnt != '0) begin
                        show_cnt <= show_cnt - 1'b1;
                    end else if (plane != PLANE_BITS'(`NUM_PLANES - 1)) begin
                        plane <= plane + 1'b1;
                        state <= S_FETCH;
                    end else begin
                        // row done, this is the only place the scan may stop
                        plane <= '0;
                        row   <= row + 1'b1;
                        state <= enable ? S_FETCH : S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // colour bits follow the captured pixels, steady across both shift states
    // green is one bit wider so its plane bits sit one higher
    always_comb begin
        panel.r1        = pixeldata_top.r[plane + 1];
        panel.g1        = pixeldata_top.g[plane + 2];
        panel.b1        = pixeldata_top.b[plane + 1];
        panel.r2        = pixeldata_bottom.r[plane + 1];
        panel.g2        = pixeldata_bottom.g[plane + 2];
        panel.b2        = pixeldata_bottom.b[plane + 1];
        panel.a         = row_sel;
        panel.shift_clk = (state == S_SHIFT_HI);
        panel.latch     = (state == S_LATCH);
        panel.oe_n      = (state != S_SHOW);
    end

endmodule

// ==== hw/led_panel_top.sv ====
`timescale 1ns/1ps
`include "panel_defines.svh"

module led_panel_top
    import axil_pkg::*;
    import panel_pkg::*;
(
    input  logic      clk_in,
    input  logic      reset,
    input  axil_req_t bus_req,
    output axil_rsp_t bus_rsp,
    output hub75_t    panel
);
    // host write port into the framebuffer
    logic                     fb_we;
    logic [`FB_ADDR_BITS-1:0] fb_waddr;
    fb_word_t                 fb_wdata;
    logic [3:0]               fb_wbe;
    logic                     scan_enable;
    // scan side read path
    logic [`COL_BITS-1:0]     column_address;
    logic [`ROW_BITS-1:0]     row_address;
    logic                     pixel_load_start;
    logic [`FB_ADDR_BITS-1:0] ram_address;
    logic                     ram_clk_enable;
    fb_word_t                 ram_data;
    logic                     load_busy;
    rgb565_t                  pixeldata_top;
    rgb565_t                  pixeldata_bottom;

    axil_fb_writer u_writer (
        .clk_in     (clk_in),
        .reset      (reset),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .fb_we      (fb_we),
        .fb_waddr   (fb_waddr),
        .fb_wdata   (fb_wdata),
        .fb_wbe     (fb_wbe),
        .scan_enable(scan_enable)
    );

    framebuffer_ram u_ram (
        .clk_in(clk_in),
        .we    (fb_we),
        .waddr (fb_waddr),
        .wdata (fb_wdata),
        .wbe   (fb_wbe),
        .re    (ram_clk_enable),
        .raddr (ram_address),
        .rdata (ram_data)
    );

    framebuffer_fetch u_fetch (
        .reset           (reset),
        .clk_in          (clk_in),
        .column_address  (column_address),
        .row_address     (row_address),
        .pixel_load_start(pixel_load_start),
        .ram_data_in     (ram_data),
        .ram_address     (ram_address),
        .ram_clk_enable  (ram_clk_enable),
        .load_busy       (load_busy),
        .pixeldata_top   (pixeldata_top),
        .pixeldata_bottom(pixeldata_bottom)
    );

    panel_scan u_scan (
        .clk_in          (clk_in),
        .reset           (reset),
        .enable          (scan_enable),
        .pixeldata_top   (pixeldata_top),
        .pixeldata_bottom(pixeldata_bottom),
        .load_busy       (load_busy),
        .column_address  (column_address),
        .row_address     (row_address),
        .pixel_load_start(pixel_load_start),
        .panel           (panel)
    );

endmodule

// ==== sim/tb_led_panel.sv ====
`timescale 1ns/1ps
`include "panel_defines.svh"

module tb_led_panel
    import axil_pkg::*;
    import panel_pkg::*;
();
    localparam int CLK_HALF     = 10;
    localparam int RESET_CYCLES = 16;
    // bus handshakes settle in a few cycles
    localparam int WAIT_LIMIT   = 100;
    // one full frame is about 31k cycles
    localparam int SCAN_LIMIT   = 60000;
    localparam int RUN_LIMIT    = 200000;
    // a little more than one row of the scan
    localparam int ROW_CYCLES   = 2500;
    localparam int NUM_WORDS    = 1 << `FB_ADDR_BITS;
    localparam int NUM_ENTRIES  = 12;
    localparam int FRAME_PLANES = `PIXEL_HALFHEIGHT * `NUM_PLANES;
    // r1 g1 b1 r2 g2 b2 sit at the top of the pin bundle
    localparam int COLOUR_MSB   = $bits(hub75_t) - 1;

    typedef struct packed {
        logic [`ROW_BITS-1:0] row;
        logic [`COL_BITS-1:0] col;
        rgb565_t              top;
        rgb565_t              bottom;
        logic [3:0]           strb;
        axil_resp_t           resp;
    } table_entry_t;

    logic         clk_in;
    logic         reset;
    axil_req_t    bus_req;
    axil_rsp_t    bus_rsp;
    hub75_t       panel;
    int           mismatches;
    int           failures;
    // host side view of the framebuffer
    logic [31:0]  fb_model [NUM_WORDS];
    table_entry_t stim_table [NUM_ENTRIES];
    // monitor position in the scan
    logic         mon_active;
    int           mon_row;
    int           mon_plane;
    int           shift_k;
    int           oe_low;
    int           planes_done;
    int           activity;

    initial clk_in = 1'b0;
    always #CLK_HALF clk_in = ~clk_in;

    led_panel_top UUT (
        .clk_in (clk_in),
        .reset  (reset),
        .bus_req(bus_req),
        .bus_rsp(bus_rsp),
        .panel  (panel)
    );

    task automatic check_resp(input axil_resp_t got, input axil_resp_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s response %s, expected %s",
                     $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_pixel_bits(input logic [5:0] got, input logic [5:0] exp,
                                    input string what);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s row %0d plane %0d shift %0d got %b, expected %b",
                     $time, what, mon_row, mon_plane, shift_k, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        failures++;
        $display("Error at %0t ns: timed out waiting for %s", $time, what);
    endtask

    task automatic report_and_finish;
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    // odd multiplier spreads every address bit over the whole word
    function automatic logic [31:0] fill_word(input int addr);
        logic [31:0] a;
        a = addr;
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    task automatic model_write(input int addr, input logic [31:0] data, input logic [3:0] strb);
        int i;
        for (i = 0; i < 4; i++) begin
            if (strb[i]) begin
                fb_model[addr][i*8 +: 8] = data[i*8 +: 8];
            end
        end
    endtask

    // plane p shows r bit p+1, g bit p+2, b bit p+1 of both halves
    function automatic logic [5:0] expected_bits(input int row, input int plane, input int col);
        fb_word_t w;
        w = fb_word_t'(fb_model[row * `PANEL_WIDTH + col]);
        return {w.top.r[plane+1], w.top.g[plane+2], w.top.b[plane+1],
                w.bottom.r[plane+1], w.bottom.g[plane+2], w.bottom.b[plane+1]};
    endfunction

    function automatic table_entry_t make_entry(input int row, input int col,
                                                input logic [15:0] top, input logic [15:0] bottom,
                                                input logic [3:0] strb);
        table_entry_t e;
        e.row    = row[`ROW_BITS-1:0];
        e.col    = col[`COL_BITS-1:0];
        e.top    = rgb565_t'(top);
        e.bottom = rgb565_t'(bottom);
        e.strb   = strb;
        e.resp   = RESP_OKAY;
        return e;
    endfunction

    // stall holds bready low for that many cycles once bvalid is up
    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int stall, output axil_resp_t resp);
        int t;
        axil_resp_t first;
        @(negedge clk_in);
        bus_req.awaddr  = addr;
        bus_req.awvalid = 1'b1;
        bus_req.wdata   = data;
        bus_req.wstrb   = strb;
        bus_req.wvalid  = 1'b1;
        t = 0;
        while (!(bus_rsp.awready && bus_rsp.wready) && t < WAIT_LIMIT) begin
            @(negedge clk_in);
            t++;
        end
        if (!(bus_rsp.awready && bus_rsp.wready)) begin
            report_timeout("awready and wready");
        end
        // transfer happened on the rising edge just passed
        @(negedge clk_in);
        bus_req.awvalid = 1'b0;
        bus_req.wvalid  = 1'b0;
        t = 0;
        while (!bus_rsp.bvalid && t < WAIT_LIMIT) begin
            @(negedge clk_in);
            t++;
        end
        if (!bus_rsp.bvalid) begin
            report_timeout("bvalid");
        end
        first = bus_rsp.bresp;
        repeat (stall) begin
            @(negedge clk_in);
            if (!bus_rsp.bvalid) begin
                failures++;
                $display("Error at %0t ns: bvalid fell before bready was raised", $time);
            end
            check_resp(bus_rsp.bresp, first, "stalled write");
        end
        bus_req.bready = 1'b1;
        @(negedge clk_in);
        bus_req.bready = 1'b0;
        resp = first;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [31:0] data,
                            output axil_resp_t resp);
        int t;
        @(negedge clk_in);
        bus_req.araddr  = addr;
        bus_req.arvalid = 1'b1;
        t = 0;
        while (!bus_rsp.arready && t < WAIT_LIMIT) begin
            @(negedge clk_in);
            t++;
        end
        if (!bus_rsp.arready) begin
            report_timeout("arready");
        end
        @(negedge clk_in);
        bus_req.arvalid = 1'b0;
        t = 0;
        while (!bus_rsp.rvalid && t < WAIT_LIMIT) begin
            @(negedge clk_in);
            t++;
        end
        if (!bus_rsp.rvalid) begin
            report_timeout("rvalid");
        end
        data = bus_rsp.rdata;
        resp = bus_rsp.rresp;
        bus_req.rready = 1'b1;
        @(negedge clk_in);
        bus_req.rready = 1'b0;
    endtask

    // panel pins are steady at the falling edge
    always @(negedge clk_in) begin
        if (!reset) begin
            if (panel.shift_clk || panel.latch || !panel.oe_n) begin
                activity++;
            end
            if (mon_active) begin
                // shift k carries column 63-k
                if (panel.shift_clk && shift_k < `PANEL_WIDTH) begin
                    check_pixel_bits(panel[COLOUR_MSB -: 6],
                                     expected_bits(mon_row, mon_plane, `PANEL_WIDTH - 1 - shift_k),
                                     "colour bits");
                end
                if (panel.shift_clk) begin
                    shift_k++;
                end
                if (panel.latch) begin
                    check_count(shift_k, `PANEL_WIDTH, "shift clocks before latch");
                    check_count(int'(panel.a), mon_row, "row address at latch");
                    shift_k = 0;
                end
                if (!panel.oe_n) begin
                    oe_low++;
                end else if (oe_low != 0) begin
                    // a show period has ended and the next plane follows
                    check_count(oe_low, `OE_BASE_CYCLES << mon_plane, "oe_n low cycles");
                    oe_low = 0;
                    planes_done++;
                    if (mon_plane == `NUM_PLANES - 1) begin
                        mon_plane = 0;
                        mon_row   = (mon_row + 1) % `PIXEL_HALFHEIGHT;
                    end else begin
                        mon_plane++;
                    end
                end
            end
        end
    end

    // overall guard against a hung run
    initial begin
        repeat (RUN_LIMIT) @(posedge clk_in);
        failures++;
        $display("Error at %0t ns: simulation ran past its cycle limit", $time);
        report_and_finish();
    end

    initial begin
        int           t;
        int           i;
        int           a;
        int           act_start;
        axil_resp_t   resp;
        logic [31:0]  rdata;
        table_entry_t e;
        void'($urandom(61605));
        mismatches  = 0;
        failures    = 0;
        mon_active  = 1'b0;
        mon_row     = 0;
        mon_plane   = 0;
        shift_k     = 0;
        oe_low      = 0;
        planes_done = 0;
        activity    = 0;
        bus_req     = '0;
        reset       = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_in);
        @(negedge clk_in);
        reset = 1'b0;
        check_count(int'({bus_rsp.awready, bus_rsp.wready, bus_rsp.bvalid,
                          bus_rsp.arready, bus_rsp.rvalid}), 0, "bus handshakes after reset");

        // dark panel while the scan is off
        act_start = activity;
        repeat (ROW_CYCLES) @(posedge clk_in);
        check_count(activity - act_start, 0, "panel activity while disabled");

        // every word gets a known value first
        for (a = 0; a < NUM_WORDS; a++) begin
            fb_model[a] = fill_word(a);
            bus_write(16'(a << 2), fill_word(a), 4'hf, 0, resp);
            check_resp(resp, RESP_OKAY, "framebuffer fill");
        end

        // corners, two partial strobes, then random pixels
        stim_table[0] = make_entry(0, 0, 16'hffff, 16'h0000, 4'hf);
        stim_table[1] = make_entry(0, 63, 16'h0000, 16'hffff, 4'hf);
        stim_table[2] = make_entry(15, 0, 16'hf81f, 16'h07e0, 4'hf);
        stim_table[3] = make_entry(15, 63, 16'h5555, 16'haaaa, 4'hf);
        stim_table[4] = make_entry(1, 10, 16'hffff, 16'hffff, 4'b0011);
        stim_table[5] = make_entry(1, 11, 16'h0000, 16'h0000, 4'b1100);
        for (i = 6; i < NUM_ENTRIES; i++) begin
            stim_table[i] = make_entry($urandom_range(15), $urandom_range(63), 16'($urandom),
                                       16'($urandom), 4'($urandom_range(15, 1)));
        end
        for (i = 0; i < NUM_ENTRIES; i++) begin
            e = stim_table[i];
            a = int'({e.row, e.col});
            model_write(a, {e.bottom, e.top}, e.strb);
            bus_write(16'(a << 2), {e.bottom, e.top}, e.strb, 0, resp);
            check_resp(resp, e.resp, "table write");
        end

        // slow master where each write follows a stalled one
        for (i = 0; i < 3; i++) begin
            a     = $urandom_range(NUM_WORDS - 1);
            rdata = $urandom;
            model_write(a, rdata, 4'hf);
            bus_write(16'(a << 2), rdata, 4'hf, $urandom_range(8, 1), resp);
            check_resp(resp, RESP_OKAY, "stalled write");
        end

        // unmapped space and the write only framebuffer
        bus_write(16'h1004, 32'h1, 4'hf, $urandom_range(6, 1), resp);
        check_resp(resp, RESP_SLVERR, "unmapped write");
        bus_read(16'h2000, rdata, resp);
        check_resp(resp, RESP_SLVERR, "unmapped read");
        check_count(int'(rdata), 0, "unmapped read data");
        bus_read(16'h0040, rdata, resp);
        check_resp(resp, RESP_SLVERR, "framebuffer read");
        check_count(int'(rdata), 0, "framebuffer read data");
        bus_read(`CTRL_ADDR, rdata, resp);
        check_resp(resp, RESP_OKAY, "control read");
        check_count(int'(rdata), 0, "enable bit before start");

        mon_active = 1'b1;
        bus_write(`CTRL_ADDR, 32'h1, 4'h1, 0, resp);
        check_resp(resp, RESP_OKAY, "enable write");
        bus_read(`CTRL_ADDR, rdata, resp);
        check_resp(resp, RESP_OKAY, "control read");
        check_count(int'(rdata), 1, "enable bit after start");

        // whole frame plus the first plane of the next
        t = 0;
        while (planes_done < FRAME_PLANES + 1 && t < SCAN_LIMIT) begin
            @(posedge clk_in);
            t++;
        end
        if (planes_done < FRAME_PLANES + 1) begin
            report_timeout("a full frame of scan");
        end

        // scan finishes row 0 and then stops
        bus_write(`CTRL_ADDR, 32'h0, 4'h1, 0, resp);
        check_resp(resp, RESP_OKAY, "disable write");
        t = 0;
        while (planes_done < FRAME_PLANES + `NUM_PLANES && t < SCAN_LIMIT) begin
            @(posedge clk_in);
            t++;
        end
        if (planes_done < FRAME_PLANES + `NUM_PLANES) begin
            report_timeout("the last row after disable");
        end
        act_start = activity;
        repeat (ROW_CYCLES) @(posedge clk_in);
        check_count(activity - act_start, 0, "panel activity after disable");
        check_count(planes_done, FRAME_PLANES + `NUM_PLANES, "planes shown in total");
        report_and_finish();
    end

endmodule

// ==== src.f ====
+incdir+hw
hw/axil_pkg.sv
hw/panel_pkg.sv
hw/timeout.sv
hw/framebuffer_ram.sv
hw/framebuffer_fetch.sv
hw/axil_fb_writer.sv
hw/panel_scan.sv
hw/led_panel_top.sv
sim/tb_led_panel.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the LED panel testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f src.f --top-module tb_led_panel -o tb_led_panel > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/tb_led_panel > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides pass or fail
if grep -q "^Result: PASSED$" "$SIM_LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $SIM_LOG"
exit 1
